//--- design/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

  // Payload of one serial frame.
  typedef logic [7:0] uart_byte_t;

  // Clocks in one bit time.
  localparam int CLKS_PER_BIT = 434;

  // Start bit, eight data bits, even parity and one stop bit.
  localparam int FRAME_BITS = 11;

  // Position of the current bit inside a frame. Bit 0 is the start bit.
  typedef logic [3:0] bit_cnt_t;

  // Clock count inside one bit time.
  typedef logic [8:0] baud_cnt_t;

endpackage

`default_nettype wire

//--- design/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  // Bit 15 is the write flag, bits 14 to 8 the address, bits 7 to 0 the write data.
  typedef logic [15:0] uart_cmd_t;

  typedef logic [6:0] reg_addr_t;

  // Idle clocks between the address frame and the data frame of a write.
  localparam int GAP_CLKS = 16;

  typedef logic [4:0] gap_cnt_t;

  typedef enum logic [2:0] {
    CMD_IDLE,
    CMD_ADDR_FRAME,
    CMD_GAP,
    CMD_DATA_FRAME,
    CMD_WAIT_REPLY,
    CMD_REPORT
  } cmd_state_t;

endpackage

`default_nettype wire

//--- design/uart_tx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        tx_start,
  input  wire uart_frame_pkg::uart_byte_t tx_byte,
  output logic                       tx,
  output logic                       tx_done
);

  import uart_frame_pkg::*;

  logic [FRAME_BITS-1:0] frame_q;
  logic                  busy;
  baud_cnt_t             baud_cnt;
  bit_cnt_t              bit_cnt;
  logic                  bit_end;
  logic                  last_bit;
  logic                  parity;

  // The parity bit makes the number of ones over data and parity even.
  assign parity = ^tx_byte;

  assign bit_end  = busy && (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
  assign last_bit = (bit_cnt == bit_cnt_t'(FRAME_BITS - 1));

  // The whole frame sits in a shift register, start bit at the bottom.
  // Ones are shifted in behind it, so the line rests high once the stop bit is out.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      frame_q  <= '1;
    end
    else if (tx_start && !busy)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      frame_q  <= {1'b1, parity, tx_byte, 1'b0};
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        frame_q  <= {1'b1, frame_q[FRAME_BITS-1:1]};
        if (last_bit)
        begin
          busy    <= 1'b0;
          bit_cnt <= '0;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  assign tx = frame_q[0];

  // High in the last clock of the stop bit
  assign tx_done = bit_end && last_bit;

endmodule

`default_nettype wire

//--- design/uart_rx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         rx,
  output logic                        rx_valid,
  output uart_frame_pkg::uart_byte_t  rx_byte,
  output logic                        rx_bad
);

  import uart_frame_pkg::*;

  logic [1:0] rx_sync;
  logic       rx_s;
  logic       rx_d;
  logic       busy;
  baud_cnt_t  baud_cnt;
  bit_cnt_t   bit_cnt;
  uart_byte_t data_q;
  logic       parity_err;
  logic       start_edge;
  logic       sample;
  logic       is_start;
  logic       is_data;
  logic       is_parity;
  logic       is_stop;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync <= 2'b11;
      rx_d    <= 1'b1;
    end
    else
    begin
      rx_sync <= {rx_sync[0], rx};
      rx_d    <= rx_s;
    end
  end

  assign rx_s       = rx_sync[1];
  assign start_edge = !busy && rx_d && !rx_s;

  assign is_start  = (bit_cnt == '0);
  assign is_data   = !is_start && (bit_cnt <= bit_cnt_t'($bits(uart_byte_t)));
  assign is_parity = (bit_cnt == bit_cnt_t'(FRAME_BITS - 2));
  assign is_stop   = (bit_cnt == bit_cnt_t'(FRAME_BITS - 1));

  // The start bit is checked half a bit after the edge. Every later sample
  // follows one full bit on, which puts it in the middle of its bit.
  always_comb
  begin
    if (is_start)
      sample = busy && (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
    else
      sample = busy && (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_bad   <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (start_edge)
      begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        bit_cnt  <= bit_cnt + 1'b1;
        if (is_start && rx_s)
        begin
          // Glitch on the line, not a real start bit.
          busy <= 1'b0;
        end
        else if (is_stop)
        begin
          busy     <= 1'b0;
          rx_valid <= 1'b1;
          rx_bad   <= parity_err || !rx_s;
        end
      end
      else if (busy)
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && is_data)
      data_q <= {rx_s, data_q[$bits(uart_byte_t)-1:1]};
    if (sample && is_parity)
      parity_err <= (rx_s != ^data_q);
  end

  assign rx_byte = data_q;

endmodule

`default_nettype wire

//--- design/uart_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_ctrl (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire uart_cmd_pkg::uart_cmd_t cmd_in,
  input  wire                         cmd_vld,
  output logic                        cmd_rdy,
  output logic                        tx_start,
  output uart_frame_pkg::uart_byte_t  tx_byte,
  input  wire                         tx_done,
  input  wire                         rx_valid,
  input  wire uart_frame_pkg::uart_byte_t rx_byte,
  input  wire                         rx_bad,
  output logic                        read_rdy,
  output uart_frame_pkg::uart_byte_t  read_data,
  output logic                        read_err
);

  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;

  cmd_state_t state_q;
  cmd_state_t state_d;
  uart_cmd_t  cmd_q;
  gap_cnt_t   gap_cnt;
  reg_addr_t  addr;
  uart_byte_t wdata;
  uart_byte_t reply_q;
  logic       reply_bad;
  logic       is_write;
  logic       accept;
  logic       gap_end;

  assign is_write = cmd_q[15];
  assign addr     = cmd_q[14:8];
  assign wdata    = cmd_q[7:0];

  assign cmd_rdy = (state_q == CMD_IDLE);
  assign accept  = cmd_vld && cmd_rdy;
  assign gap_end = (state_q == CMD_GAP) && (gap_cnt == gap_cnt_t'(GAP_CLKS - 1));

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      CMD_IDLE:
        if (accept)
          state_d = CMD_ADDR_FRAME;
      CMD_ADDR_FRAME:
        if (tx_done)
          state_d = is_write ? CMD_GAP : CMD_WAIT_REPLY;
      CMD_GAP:
        if (gap_end)
          state_d = CMD_DATA_FRAME;
      CMD_DATA_FRAME:
        if (tx_done)
          state_d = CMD_IDLE;
      CMD_WAIT_REPLY:
        if (rx_valid)
          state_d = CMD_REPORT;
      CMD_REPORT:
        state_d = CMD_IDLE;
      default:
        state_d = CMD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= CMD_IDLE;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
    end
    else
    begin
      state_q <= state_d;
      // One pulse per frame in the first cycle of the frame's state.
      tx_start <= accept || gap_end;
      if (state_q == CMD_GAP)
        gap_cnt <= gap_cnt + 1'b1;
      else
        gap_cnt <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if ((state_q == CMD_WAIT_REPLY) && rx_valid)
    begin
      reply_q   <= rx_byte;
      reply_bad <= rx_bad;
    end
  end

  // The address frame is the upper command byte with the write flag in bit 7.
  assign tx_byte = (state_q == CMD_DATA_FRAME) ? wdata : {is_write, addr};

  assign read_data = reply_q;
  assign read_rdy  = (state_q == CMD_REPORT) && !reply_bad;
  assign read_err  = (state_q == CMD_REPORT) && reply_bad;

endmodule

`default_nettype wire

//--- design/uart_cmd_host.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_host (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire uart_cmd_pkg::uart_cmd_t cmd_in,
  input  wire                         cmd_vld,
  output logic                        cmd_rdy,
  input  wire                         rx,
  output logic                        tx,
  output logic                        read_rdy,
  output uart_frame_pkg::uart_byte_t  read_data,
  output logic                        read_err
);

  import uart_frame_pkg::*;

  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_done;
  logic       rx_valid;
  uart_byte_t rx_byte;
  logic       rx_bad;

  uart_cmd_ctrl i_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_bad    (rx_bad),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  // The receiver listens all the time and the controller picks out the reply.
  uart_rx_frame i_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_bad   (rx_bad)
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- test/uart_cmd_host_props.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_host_props (
  input wire clk,
  input wire rst_n,
  input wire cmd_vld,
  input wire cmd_rdy,
  input wire tx,
  input wire read_rdy,
  input wire read_err
);

  // The line rests high whenever the host can take a command.
  idle_line_a: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx is low while cmd_rdy is high");

  one_result_a: assert property (@(posedge clk) disable iff (!rst_n) !(read_rdy && read_err))
    else $error("read_rdy and read_err are high together");

  rdy_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy lasts more than one cycle");

  err_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) read_err |=> !read_err)
    else $error("read_err lasts more than one cycle");

  accept_a: assert property (@(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else $error("cmd_rdy stays high after a command was accepted");

endmodule

bind uart_cmd_host uart_cmd_host_props i_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy),
  .read_err (read_err)
);

`default_nettype wire

//--- test/tb_uart_cmd_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_host;

  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;

  localparam int WAIT_LIMIT  = 3 * FRAME_BITS * CLKS_PER_BIT;
  localparam int BUSY_CYCLES = 40;
  localparam logic [39:0] OUT_WRITE = "write";
  localparam logic [39:0] OUT_DATA  = {8'h00, "data"};
  localparam logic [39:0] OUT_ERROR = "error";

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  logic       read_rdy;
  uart_byte_t read_data;
  logic       read_err;
  logic       strobe_allowed;

  tb_clock #(.PERIOD_NS(20)) i_clock (.clk(clk));

  uart_cmd_host i_uart_cmd_host (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic wait_ticks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // The host must keep the line idle until it is ready again.
  task automatic wait_ready();
    int waited;
    waited = 0;
    while (cmd_rdy !== 1'b1)
    begin
      assert (tx === 1'b1)
      else abort_run($sformatf("FAILED tx: got %h, expected 1 after the last frame", tx));
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("Timeout waiting for cmd_rdy to return");
    end
  endtask

  // Decodes one frame on tx by sampling the middle of each bit.
  task automatic recv_frame(input string what, output uart_byte_t data);
    int         waited;
    logic [9:0] bits;
    waited = 0;
    while (tx !== 1'b0)
    begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run($sformatf("Timeout waiting for the %s frame on tx", what));
    end
    wait_ticks(CLKS_PER_BIT / 2);
    assert (tx === 1'b0)
    else abort_run($sformatf("The start bit of the %s frame ended too early", what));
    for (int i = 0; i < FRAME_BITS - 1; i++)
    begin
      wait_ticks(CLKS_PER_BIT);
      bits[i] = tx;
    end
    data = bits[7:0];
    assert (bits[8] === ^bits[7:0])
    else abort_run($sformatf("FAILED tx parity of %s frame: got %h, expected %h",
                             what, bits[8], ^bits[7:0]));
    assert (bits[9] === 1'b1)
    else abort_run($sformatf("FAILED tx stop bit of %s frame: got %h, expected 1", what, bits[9]));
  endtask

  // Keeps cmd_vld up with another command while the host is busy.
  task automatic hold_busy_cmd(input uart_cmd_t other);
    cmd_in = other;
    for (int i = 0; i < BUSY_CYCLES; i++)
    begin
      assert (cmd_rdy === 1'b0)
      else abort_run($sformatf("FAILED cmd_rdy: got %h, expected 0 while busy", cmd_rdy));
      @(negedge clk);
    end
    cmd_vld = 1'b0;
  endtask

  task automatic send_reply(input uart_byte_t data, input logic corrupt, input int delay);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, (^data) ^ corrupt, data, 1'b0};
    wait_ticks(delay);
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rx = frame[i];
      wait_ticks(CLKS_PER_BIT);
    end
  endtask

  task automatic wait_strobe(input logic expect_err, input uart_byte_t expect_data);
    int waited;
    waited = 0;
    while (read_rdy !== 1'b1 && read_err !== 1'b1)
    begin
      assert (tx === 1'b1)
      else abort_run($sformatf("FAILED tx: got %h, expected 1 during the reply", tx));
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("Timeout waiting for read_rdy or read_err");
    end
    assert (read_err === expect_err)
    else abort_run($sformatf("FAILED read_err: got %h, expected %h", read_err, expect_err));
    assert (read_rdy === !expect_err)
    else abort_run($sformatf("FAILED read_rdy: got %h, expected %h", read_rdy, !expect_err));
    if (!expect_err)
      assert (read_data === expect_data)
      else abort_run($sformatf("FAILED read_data: got %h, expected %h", read_data, expect_data));
  endtask

  task automatic run_command(input uart_cmd_t cmd, input uart_byte_t reply, input logic corrupt,
                             input logic [39:0] outcome, input int unsigned gap);
    uart_byte_t got_addr;
    uart_byte_t got_data;
    int         delay;
    delay = int'($urandom % 40);
    if (cmd[15] != (outcome == OUT_WRITE) || (!cmd[15] && outcome != OUT_DATA
        && outcome != OUT_ERROR))
      abort_run($sformatf("Pattern line for command %h has an unusable expected result", cmd));
    wait_ready();
    wait_ticks(int'(gap));
    strobe_allowed = !cmd[15];
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    fork
      hold_busy_cmd(~cmd);
      recv_frame("address", got_addr);
    join
    assert (got_addr === cmd[15:8])
    else abort_run($sformatf("FAILED tx address frame: got %h, expected %h",
                             got_addr, cmd[15:8]));
    if (cmd[15])
    begin
      recv_frame("data", got_data);
      assert (got_data === cmd[7:0])
      else abort_run($sformatf("FAILED tx data frame: got %h, expected %h", got_data, cmd[7:0]));
    end
    else
    begin
      fork
        send_reply(reply, corrupt, delay);
        wait_strobe(outcome == OUT_ERROR, reply);
      join
    end
  endtask

  // Read strobes may only show up while a read is running.
  always @(negedge clk)
  begin
    if (rst_n === 1'b1 && strobe_allowed === 1'b0)
      assert (read_rdy === 1'b0 && read_err === 1'b0)
      else abort_run($sformatf("FAILED read_rdy/read_err: got %h/%h, expected 0/0",
                               read_rdy, read_err));
  end

  initial
  begin : main
    int          fd;
    int          n;
    int          count;
    int unsigned gap;
    string       line;
    uart_cmd_t   cmd;
    uart_byte_t  reply;
    logic        corrupt;
    logic [39:0] outcome;
    void'($urandom(32'hee0ad6c7));
    rst_n          = 1'b0;
    cmd_in         = '0;
    cmd_vld        = 1'b0;
    rx             = 1'b1;
    strobe_allowed = 1'b0;
    wait_ticks(3);
    rst_n = 1'b1;
    @(negedge clk);
    assert (tx === 1'b1 && cmd_rdy === 1'b1 && read_rdy === 1'b0 && read_err === 1'b0)
    else abort_run($sformatf("FAILED tx/cmd_rdy/read_rdy/read_err: got %h/%h/%h/%h, expected 1/1/0/0",
                             tx, cmd_rdy, read_rdy, read_err));
    fd = $fopen("test/uart_patterns.txt", "r");
    if (fd == 0)
      abort_run("Could not open test/uart_patterns.txt");
    count = 0;
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#")
      begin
        outcome = '0;
        n = $sscanf(line, "%h %h %h %s", cmd, reply, corrupt, outcome);
        if (n != 4)
          abort_run($sformatf("Malformed line in the pattern file: %s", line));
        // Every third command goes out as soon as cmd_rdy is back.
        gap = (count % 3 == 0) ? 32'd0 : $urandom % 21;
        run_command(cmd, reply, corrupt, outcome, gap);
        count++;
      end
    end
    $fclose(fd);
    wait_ready();
    if (count > 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      abort_run("The pattern file holds no commands");
    end
  end

endmodule

`default_nettype wire

//--- test/uart_patterns.txt
# command(hex) reply(hex) corrupt(0/1) expected(write/data/error)
# The reply byte and the corrupt flag only matter for reads.
8a5c 00 0 write
0a00 5c 0 data
ff01 00 0 write
7f00 a7 0 data
1300 3c 1 error
8080 00 0 write
0000 ff 0 data
0100 00 0 data
9ee7 00 0 write
1e00 81 1 error
2200 96 0 data
c5aa 00 0 write
c455 00 0 write
4500 55 0 data
3300 0f 1 error
b1fe 00 0 write
3100 e0 0 data

//--- sim.f
design/uart_frame_pkg.sv
design/uart_cmd_pkg.sv
design/uart_tx_frame.sv
design/uart_rx_frame.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_host.sv
test/tb_clock.sv
test/uart_cmd_host_props.sv
test/tb_uart_cmd_host.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_uart_cmd_host -f sim.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Everything OK$" &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }
